// File: logic/exp_fixed_pkg.sv
package exp_fixed_pkg;

	// Q16.16 data path
	localparam int FIX_WIDTH = 32;
	localparam int FIX_FRAC = 16;

	// segment index taken from 3 integer and 4 fraction bits of the magnitude
	localparam int SEG_INT_WIDTH = 3;
	localparam int SEG_FRAC_WIDTH = 4;
	localparam int SEG_INDEX_WIDTH = SEG_INT_WIDTH + SEG_FRAC_WIDTH;
	localparam int SEG_COUNT = 1 << SEG_INDEX_WIDTH;

	// signed fixed-point value
	typedef logic signed [FIX_WIDTH-1:0] fix_t;

	// segment number in 1/16 steps over 0 to 8
	typedef logic [SEG_INDEX_WIDTH-1:0] seg_index_t;

	// full width signed product of two fix_t values
	typedef logic signed [2*FIX_WIDTH-1:0] fix_product_t;

endpackage

// File: logic/exp_table_pkg.sv
package exp_table_pkg;
	import exp_fixed_pkg::*;

	// Q16.16 slope in the upper word and Q16.16 intercept in the lower word
	localparam logic [2*FIX_WIDTH-1:0] seg_table [SEG_COUNT] = '{
		// magnitude 0.0 to 1.0
		64'h0000F82A_00010000,
		64'h0000E920_0000FF0F,
		64'h0000DB01_0000FD4B,
		64'h0000CDBC_0000FACE,
		64'h0000C145_0000F7B0,
		64'h0000B58F_0000F408,
		64'h0000AA8F_0000EFE8,
		64'h0000A03A_0000EB62,
		64'h00009684_0000E688,
		64'h00008D66_0000E166,
		64'h000084D5_0000DC0C,
		64'h00007CC8_0000D683,
		64'h00007539_0000D0D8,
		64'h00006E1F_0000CB12,
		64'h00006773_0000C53C,
		64'h0000612E_0000BF5C,
		// magnitude 1.0 to 2.0
		64'h00005B4B_0000B978,
		64'h000055C3_0000B398,
		64'h00005091_0000ADBF,
		64'h00004BAF_0000A7F3,
		64'h00004719_0000A238,
		64'h000042CA_00009C91,
		64'h00003EBE_00009700,
		64'h00003AF1_00009189,
		64'h0000375F_00008C2E,
		64'h00003404_000086F0,
		64'h000030DD_000081D1,
		64'h00002DE7_00007CD2,
		64'h00002B1F_000077F4,
		64'h00002882_00007337,
		64'h0000260E_00006E9D,
		64'h000023C0_00006A26,
		// magnitude 2.0 to 3.0
		64'h00002195_000065D1,
		64'h00001F8C_0000619E,
		64'h00001DA3_00005D8E,
		64'h00001BD7_000059A1,
		64'h00001A28_000055D5,
		64'h00001892_0000522B,
		64'h00001715_00004EA2,
		64'h000015AF_00004B39,
		64'h0000145E_000047F0,
		64'h00001322_000044C7,
		64'h000011FA_000041BB,
		64'h000010E3_00003ECE,
		64'h00000FDD_00003BFE,
		64'h00000EE7_0000394A,
		64'h00000E00_000036B1,
		64'h00000D26_00003433,
		// magnitude 3.0 to 4.0
		64'h00000C5A_000031CF,
		64'h00000B9B_00002F84,
		64'h00000AE7_00002D52,
		64'h00000A3E_00002B37,
		64'h0000099F_00002932,
		64'h0000090A_00002744,
		64'h0000087D_0000256B,
		64'h000007FA_000023A6,
		64'h0000077E_000021F5,
		64'h0000070A_00002057,
		64'h0000069D_00001ECB,
		64'h00000636_00001D51,
		64'h000005D6_00001BE8,
		64'h0000057B_00001A8E,
		64'h00000526_00001945,
		64'h000004D6_0000180A,
		// magnitude 4.0 to 5.0
		64'h0000048B_000016DE,
		64'h00000445_000015C0,
		64'h00000402_000014AF,
		64'h000003C4_000013AA,
		64'h0000038A_000012B2,
		64'h00000353_000011C5,
		64'h0000031F_000010E3,
		64'h000002EF_0000100C,
		64'h000002C1_00000F3F,
		64'h00000296_00000E7C,
		64'h0000026E_00000DC3,
		64'h00000249_00000D12,
		64'h00000225_00000C69,
		64'h00000204_00000BC9,
		64'h000001E5_00000B31,
		64'h000001C7_00000A9F,
		// magnitude 5.0 to 6.0
		64'h000001AC_00000A15,
		64'h00000192_00000992,
		64'h00000179_00000915,
		64'h00000162_0000089E,
		64'h0000014D_0000082E,
		64'h00000139_000007C2,
		64'h00000126_0000075C,
		64'h00000114_000006FB,
		64'h00000103_0000069F,
		64'h000000F3_00000648,
		64'h000000E5_000005F5,
		64'h000000D7_000005A6,
		64'h000000CA_0000055B,
		64'h000000BD_00000514,
		64'h000000B2_000004D0,
		64'h000000A7_00000490,
		// magnitude 6.0 to 7.0
		64'h0000009D_00000453,
		64'h00000093_00000419,
		64'h0000008A_000003E2,
		64'h00000082_000003AE,
		64'h0000007A_0000037D,
		64'h00000073_0000034E,
		64'h0000006C_00000321,
		64'h00000065_000002F7,
		64'h0000005F_000002CF,
		64'h00000059_000002A9,
		64'h00000054_00000285,
		64'h0000004F_00000263,
		64'h0000004A_00000242,
		64'h00000045_00000224,
		64'h00000041_00000207,
		64'h0000003D_000001EB,
		// magnitude 7.0 to 8.0 and everything beyond on the last entry
		64'h00000039_000001D1,
		64'h00000036_000001B8,
		64'h00000033_000001A1,
		64'h00000030_0000018A,
		64'h0000002D_00000175,
		64'h0000002A_00000161,
		64'h00000027_0000014E,
		64'h00000025_0000013C,
		64'h00000023_0000012B,
		64'h00000021_0000011B,
		64'h0000001F_0000010C,
		64'h0000001D_000000FD,
		64'h0000001B_000000F0,
		64'h00000019_000000E3,
		64'h00000018_000000D7,
		64'h00000016_000000CB
	};

	function automatic fix_t seg_slope(input seg_index_t index);
		return fix_t'(seg_table[index][2*FIX_WIDTH-1:FIX_WIDTH]);
	endfunction

	function automatic fix_t seg_intercept(input seg_index_t index);
		return fix_t'(seg_table[index][FIX_WIDTH-1:0]);
	endfunction

endpackage

// File: logic/pwl_term_if.sv
`timescale 1ns/100ps

// one operand travelling with the slope and intercept of its segment
interface pwl_term_if
	import exp_fixed_pkg::*;
();
	fix_t operand;
	fix_t slope;
	fix_t intercept;
	logic run;

	// lookup side
	modport source (
		output operand,
		output slope,
		output intercept,
		output run
	);

	// multiply-add side
	modport sink (
		input operand,
		input slope,
		input intercept,
		input run
	);

endinterface

// File: logic/segment_select.sv
`timescale 1ns/100ps

module segment_select
	import exp_fixed_pkg::*;
	import exp_table_pkg::*;
(
	input fix_t a,
	input logic stage_run,
	pwl_term_if.source term
);

	fix_t neg_a;
	logic overflow;
	seg_index_t index;

	// magnitude of a non-positive operand
	assign neg_a = -a;

	// 8.0 or more, a positive operand, or 8000_0000 which stays negative
	assign overflow = |neg_a[FIX_WIDTH-1:FIX_FRAC+SEG_INT_WIDTH];

	always_comb begin
		if (overflow) begin
			index = '1;
		end else begin
			index = neg_a[FIX_FRAC+SEG_INT_WIDTH-1:FIX_FRAC-SEG_FRAC_WIDTH];
		end
	end

	assign term.operand = a;
	assign term.slope = seg_slope(index);
	assign term.intercept = seg_intercept(index);
	assign term.run = stage_run;

	// positive operands and those at or below -8.0 leave on the last segment
	saturate_to_last: assert final (!(a > 0 || a <= -(1 << (FIX_FRAC + SEG_INT_WIDTH)))
		|| &index)
	else
		$error("operand %h out of range but segment %0d selected", a, index);

endmodule

// File: logic/pwl_mac.sv
`timescale 1ns/100ps

module pwl_mac
	import exp_fixed_pkg::*;
(
	input logic clk,
	input logic reset,
	pwl_term_if.sink term,
	output fix_t z
);

	fix_product_t product;
	fix_t product_reg;
	fix_t intercept_reg;

	// Q16.16 times Q16.16 gives Q32.32
	assign product = fix_product_t'(term.operand) * fix_product_t'(term.slope);

	always_ff @(posedge clk) begin
		if (reset) begin
			product_reg <= '0;
			intercept_reg <= '0;
		end else if (term.run) begin
			// middle word brings the product back to Q16.16
			product_reg <= product[FIX_WIDTH+FIX_FRAC-1:FIX_FRAC];
			intercept_reg <= term.intercept;
		end
	end

	// wraps modulo 2^32
	assign z = product_reg + intercept_reg;

	hold_without_run: assert property (
		@(posedge clk) disable iff (reset)
		!term.run |=> $stable(product_reg) && $stable(intercept_reg)
	) else
		$error("pipeline register changed without run");

	clear_after_reset: assert property (
		@(posedge clk)
		reset |=> product_reg == '0 && intercept_reg == '0
	) else
		$error("pipeline register not cleared by reset");

endmodule

// File: logic/exp_unit.sv
`timescale 1ns/100ps

module exp_unit
	import exp_fixed_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic stage_run,
	input fix_t a,
	output fix_t z
);

	pwl_term_if term ();

	// combinational lookup of the segment for a
	segment_select u_select (
		.a(a),
		.stage_run(stage_run),
		.term(term.source)
	);

	// one register stage, then the add
	pwl_mac u_mac (
		.clk(clk),
		.reset(reset),
		.term(term.sink),
		.z(z)
	);

	// result only moves on a stage_run edge or reset
	z_holds_while_idle: assert property (
		@(posedge clk) disable iff (reset)
		!stage_run |=> $stable(z)
	) else
		$error("z changed while stage_run was low");

endmodule

// File: testbench/exp_model.svh
`ifndef EXP_MODEL_SVH
`define EXP_MODEL_SVH

// operands at or below -8.0, or above zero, fall on the last segment
localparam fix_t MODEL_LIMIT = 32'sh0008_0000;

// one step of the linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// segment number in 1/16 steps of the magnitude of a
function automatic seg_index_t model_index(input fix_t value);
	fix_t magnitude;
	seg_index_t index;
	if (value > 0 || value <= -MODEL_LIMIT) begin
		index = seg_index_t'(SEG_COUNT - 1);
	end else begin
		magnitude = -value;
		// one segment of 1/16 is 4096 in Q16.16
		index = seg_index_t'(magnitude / 4096);
	end
	return index;
endfunction

// slope times operand in Q16.16 plus the intercept modulo 2^32
function automatic fix_t model_result(input fix_t value);
	seg_index_t index;
	fix_t slope;
	fix_t intercept;
	logic signed [63:0] wide_a;
	logic signed [63:0] wide_slope;
	logic signed [63:0] full;
	fix_t truncated;
	index = model_index(value);
	slope = seg_slope(index);
	intercept = seg_intercept(index);
	wide_a = {{32{value[31]}}, value};
	wide_slope = {{32{slope[31]}}, slope};
	full = wide_a * wide_slope;
	// drop the low 16 fraction bits and the high integer bits
	truncated = full[47:16];
	return truncated + intercept;
endfunction

`endif

// File: testbench/exp_unit_tb.sv
`timescale 1ns/100ps

module exp_unit_tb
	import exp_fixed_pkg::*;
	import exp_table_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 4;
	localparam int RANDOM_COUNT = 400;
	localparam int SAT_FIXED = 6;
	localparam int SAT_RANDOM = 40;
	localparam int HOLD_ROUNDS = 40;
	localparam int MAX_GAP = 8;
	localparam int BOUND_COUNT = 12;
	localparam int DRAIN_CYCLES = 2;

	// worst case length of all tests in clocks
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RANDOM_COUNT
		+ SAT_FIXED + SAT_RANDOM + HOLD_ROUNDS * (1 + MAX_GAP)
		+ BOUND_COUNT * 3 + DRAIN_CYCLES;
	localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 20;

	localparam logic [31:0] LCG_SEED = 32'ha50072bc;

	// segment boundaries at -k/16
	localparam int BOUND_K [BOUND_COUNT] = '{0, 1, 2, 15, 16, 17, 63, 64, 100, 126, 127, 128};

	localparam fix_t SAT_VALUES [SAT_FIXED] = '{
		32'h8000_0000,
		32'h7fff_ffff,
		32'h0000_0001,
		32'h0001_0000,
		32'hfff8_0000,
		32'hfff7_ffff
	};

	logic clk;
	logic reset;
	logic stage_run;
	fix_t a;
	fix_t z;

	fix_t expected_z;
	logic check_en;
	logic [31:0] lcg_state;
	int error_count;
	int check_count;

	`include "exp_model.svh"

	exp_unit UUT (
		.clk(clk),
		.reset(reset),
		.stage_run(stage_run),
		.a(a),
		.z(z)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// one-entry expected value loaded whenever the DUT takes an operand
	always @(posedge clk) begin
		if (reset) begin
			expected_z <= '0;
		end else if (stage_run) begin
			expected_z <= model_result(a);
		end
	end

	// z is stable in the middle of the cycle
	always @(negedge clk) begin
		if (check_en) begin
			check_value("z", expected_z, z);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	function automatic logic [31:0] random_word();
		logic [31:0] upper;
		lcg_state = lcg_step(lcg_state);
		upper = {16'h0000, lcg_state[31:16]};
		lcg_state = lcg_step(lcg_state);
		return {upper[15:0], lcg_state[31:16]};
	endfunction

	// an operand from -8.0 up to 0
	function automatic fix_t in_range_operand();
		logic [31:0] magnitude;
		magnitude = random_word() % 32'h0008_0001;
		return fix_t'(-magnitude);
	endfunction

	task automatic drive_input(input fix_t value, input logic run);
		@(posedge clk);
		a <= value;
		stage_run <= run;
	endtask

	task automatic check_index(input seg_index_t expected);
		@(negedge clk);
		check_value("segment index", 32'(expected), 32'(UUT.u_select.index));
	endtask

	task automatic run_idle_after_reset();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			drive_input(random_word(), 1'b0);
			@(negedge clk);
			check_value("z after reset", 32'h0, z);
		end
	endtask

	task automatic run_random_operands();
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			drive_input(in_range_operand(), 1'b1);
		end
	endtask

	task automatic run_saturation();
		logic [31:0] r;
		fix_t value;
		for (int i = 0; i < SAT_FIXED; i++) begin
			drive_input(SAT_VALUES[i], 1'b1);
			check_index(seg_index_t'(SEG_COUNT - 1));
		end
		for (int i = 0; i < SAT_RANDOM; i++) begin
			r = random_word();
			if (i % 2 == 0) begin
				value = r & 32'h7fff_ffff;
				if (value == 0) begin
					value = 1;
				end
			end else begin
				// magnitude 8.0 or more
				value = -(32'h0008_0000 + (r & 32'h3fff_ffff));
			end
			drive_input(value, 1'b1);
			check_index(seg_index_t'(SEG_COUNT - 1));
		end
	endtask

	task automatic run_hold();
		fix_t value;
		int gap;
		for (int round = 0; round < HOLD_ROUNDS; round++) begin
			value = in_range_operand();
			drive_input(value, 1'b1);
			gap = 1 + int'(random_word() % MAX_GAP);
			for (int i = 0; i < gap; i++) begin
				drive_input(random_word(), 1'b0);
				@(negedge clk);
				check_value("z held", model_result(value), z);
			end
		end
	endtask

	task automatic run_boundaries();
		fix_t base;
		fix_t value;
		for (int i = 0; i < BOUND_COUNT; i++) begin
			base = fix_t'(-(BOUND_K[i] * 4096));
			for (int offset = -1; offset <= 1; offset++) begin
				value = base + fix_t'(offset);
				drive_input(value, 1'b1);
				check_index(model_index(value));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		stage_run = 1'b0;
		a = '0;
		check_en = 1'b0;
		lcg_state = LCG_SEED;
		error_count = 0;
		check_count = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_en <= 1'b1;

		run_idle_after_reset();
		run_random_operands();
		run_saturation();
		run_hold();
		run_boundaries();

		// let the last result reach z
		for (int i = 0; i < DRAIN_CYCLES; i++) begin
			drive_input('0, 1'b0);
		end
		@(negedge clk);
		check_en <= 1'b0;

		$display("errors: %0d in %0d checks", error_count, check_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: exp_unit.f
+incdir+testbench
logic/exp_fixed_pkg.sv
logic/exp_table_pkg.sv
logic/pwl_term_if.sv
logic/segment_select.sv
logic/pwl_mac.sv
logic/exp_unit.sv
testbench/exp_unit_tb.sv
